// File: design/sdcard_cfg_pkg.sv
`default_nettype none

package sdcard_cfg_pkg;

  // SPI clock divider
  typedef logic [15:0] sck_cnt_t;

  localparam sck_cnt_t SCK_PERIOD     = 16'd6;
  localparam sck_cnt_t SCK_HIGH_FIRST = 16'd1;
  localparam sck_cnt_t SCK_HIGH_LAST  = 16'd4;

  // Command and response framing
  localparam int CMD_FRAME_BITS = 48;
  localparam int RSP_MAX_BITS   = 48;
  localparam int RSP_LEN_MSB    = 62;
  localparam int RSP_LEN_LSB    = 56;

  typedef logic [63:0]                      cmd_t;
  typedef logic [RSP_MAX_BITS-1:0]          rsp_t;
  // Response length in bytes
  typedef logic [RSP_LEN_MSB-RSP_LEN_LSB:0] rsp_len_t;

endpackage

`default_nettype wire

// File: design/sdcard_reg_pkg.sv
`default_nettype none

package sdcard_reg_pkg;

  typedef logic [31:0] bus_addr_t;
  typedef logic [31:0] bus_data_t;
  // Word index, address bits 31:2
  typedef logic [29:0] reg_index_t;

  localparam reg_index_t REG_NOOP       = 30'd0;
  localparam reg_index_t REG_SEND       = 30'd1;
  localparam reg_index_t REG_CMD_LO     = 30'd2;
  localparam reg_index_t REG_CMD_HI     = 30'd3;
  localparam reg_index_t REG_RSP_STATUS = 30'd4;
  localparam reg_index_t REG_RSP_LO     = 30'd5;
  localparam reg_index_t REG_RSP_HI     = 30'd6;

endpackage

`default_nettype wire

// File: design/sdcard_sck_gen.sv
`timescale 1ns/1ps
`default_nettype none

module sdcard_sck_gen (
  input  logic clk,
  input  logic rst,
  output logic o_sck,
  output logic o_sck_tick
);

  sdcard_cfg_pkg::sck_cnt_t sck_cnt;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      sck_cnt    <= '0;
      o_sck      <= 1'b0;
      o_sck_tick <= 1'b0;
    end
    else
    begin
      // High in the middle of the bit time
      o_sck <= (sck_cnt >= sdcard_cfg_pkg::SCK_HIGH_FIRST) &&
               (sck_cnt <= sdcard_cfg_pkg::SCK_HIGH_LAST);
      o_sck_tick <= 1'b0;
      if (sck_cnt >= sdcard_cfg_pkg::SCK_PERIOD)
      begin
        sck_cnt    <= '0;
        o_sck_tick <= 1'b1;
      end
      else
      begin
        sck_cnt <= sck_cnt + 16'd1;
      end
    end
  end

endmodule

`default_nettype wire

// File: design/sdcard_bus_regs.sv
`timescale 1ns/1ps
`default_nettype none

module sdcard_bus_regs (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      i_bus_req,
  input  logic                      i_bus_write,
  input  sdcard_reg_pkg::bus_addr_t i_bus_addr,
  input  sdcard_reg_pkg::bus_data_t i_bus_data,
  input  logic                      i_busy,
  input  sdcard_cfg_pkg::rsp_t      i_rsp,
  input  logic                      i_rsp_done,
  output logic                      o_bus_ack,
  output sdcard_reg_pkg::bus_data_t o_bus_data,
  output logic                      o_send_start,
  output sdcard_cfg_pkg::cmd_t      o_cmd
);

  sdcard_reg_pkg::reg_index_t index;
  logic                       accept;
  logic                       rsp_arrived;

  assign index  = i_bus_addr[31:2];
  // Requests are only honored while no send is in flight
  assign accept = i_bus_req && !i_busy;

  assign o_send_start = accept && i_bus_write && (index == sdcard_reg_pkg::REG_SEND);

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      o_bus_ack   <= 1'b0;
      o_bus_data  <= '0;
      o_cmd       <= '0;
      rsp_arrived <= 1'b0;
    end
    else
    begin
      o_bus_ack  <= 1'b0;
      o_bus_data <= '0;

      // Completion of a send
      if (i_rsp_done)
      begin
        o_bus_ack   <= 1'b1;
        rsp_arrived <= 1'b1;
      end

      if (accept)
      begin
        case (index)
          sdcard_reg_pkg::REG_SEND:
          begin
            // Acked later, on completion
            if (i_bus_write)
            begin
              rsp_arrived <= 1'b0;
            end
          end
          sdcard_reg_pkg::REG_CMD_LO:
          begin
            if (i_bus_write)
            begin
              o_cmd[31:0] <= i_bus_data;
            end
            o_bus_ack  <= 1'b1;
            o_bus_data <= o_cmd[31:0];
          end
          sdcard_reg_pkg::REG_CMD_HI:
          begin
            if (i_bus_write)
            begin
              o_cmd[63:32] <= i_bus_data;
            end
            o_bus_ack  <= 1'b1;
            o_bus_data <= o_cmd[63:32];
          end
          sdcard_reg_pkg::REG_RSP_STATUS:
          begin
            o_bus_ack  <= 1'b1;
            o_bus_data <= {31'd0, rsp_arrived};
          end
          sdcard_reg_pkg::REG_RSP_LO:
          begin
            o_bus_ack  <= 1'b1;
            o_bus_data <= i_rsp[31:0];
          end
          sdcard_reg_pkg::REG_RSP_HI:
          begin
            o_bus_ack  <= 1'b1;
            o_bus_data <= {16'd0, i_rsp[47:32]};
          end
          // NOOP and unmapped indices
          default:
          begin
            o_bus_ack <= 1'b1;
          end
        endcase
      end
    end
  end

endmodule

`default_nettype wire

// File: design/sdcard_cmd_engine.sv
`timescale 1ns/1ps
`default_nettype none

module sdcard_cmd_engine (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 i_send_start,
  input  sdcard_cfg_pkg::cmd_t i_cmd,
  input  logic                 i_sck_tick,
  input  logic                 i_spi_ack,
  input  logic                 i_rsp_done,
  output logic                 o_busy,
  output logic                 o_spi_req,
  output logic                 o_spi_done,
  output logic                 o_cs,
  output logic                 o_mosi,
  output logic                 o_rsp_start
);

  localparam int BIT_CNT_W = $clog2(sdcard_cfg_pkg::CMD_FRAME_BITS + 1);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_ARB,
    ST_SHIFT,
    ST_RSP_WAIT
  } state_t;

  state_t               state;
  logic [BIT_CNT_W-1:0] bit_cnt;

  assign o_busy = (state != ST_IDLE);

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state       <= ST_IDLE;
      bit_cnt     <= '0;
      o_spi_req   <= 1'b0;
      o_spi_done  <= 1'b0;
      o_cs        <= 1'b1;
      o_mosi      <= 1'b1;
      o_rsp_start <= 1'b0;
    end
    else
    begin
      o_spi_done  <= 1'b0;
      o_rsp_start <= 1'b0;
      case (state)
        ST_IDLE:
        begin
          if (i_send_start)
          begin
            o_spi_req <= 1'b1;
            state     <= ST_ARB;
          end
        end
        ST_ARB:
        begin
          if (i_spi_ack)
          begin
            o_spi_req <= 1'b0;
            bit_cnt   <= BIT_CNT_W'(sdcard_cfg_pkg::CMD_FRAME_BITS);
            state     <= ST_SHIFT;
          end
        end
        ST_SHIFT:
        begin
          if (i_sck_tick)
          begin
            o_cs <= 1'b0;
            if (bit_cnt == '0)
            begin
              o_rsp_start <= 1'b1;
              state       <= ST_RSP_WAIT;
            end
            else
            begin
              // MSB first
              o_mosi  <= i_cmd[bit_cnt - 1'b1];
              bit_cnt <= bit_cnt - 1'b1;
            end
          end
        end
        default:
        begin
          if (i_rsp_done)
          begin
            o_cs       <= 1'b1;
            o_spi_done <= 1'b1;
            state      <= ST_IDLE;
          end
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// File: design/sdcard_rsp_capture.sv
`timescale 1ns/1ps
`default_nettype none

module sdcard_rsp_capture (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     i_start,
  input  logic                     i_sck_tick,
  input  logic                     i_miso,
  input  sdcard_cfg_pkg::rsp_len_t i_rsp_len,
  output sdcard_cfg_pkg::rsp_t     o_rsp,
  output logic                     o_done
);

  localparam int CNT_W = $bits(sdcard_cfg_pkg::rsp_len_t) + 3;

  logic             active;
  logic             hunting;
  logic [CNT_W-1:0] bit_cnt;
  logic [CNT_W-1:0] rsp_bits;

  // Bytes to bits
  assign rsp_bits = {i_rsp_len, 3'b000};

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      active  <= 1'b0;
      hunting <= 1'b0;
      bit_cnt <= '0;
      o_rsp   <= '0;
      o_done  <= 1'b0;
    end
    else
    begin
      o_done <= 1'b0;
      if (i_start)
      begin
        active  <= 1'b1;
        hunting <= 1'b1;
        bit_cnt <= '0;
        o_rsp   <= '0;
      end
      // Start bit is a zero, and it is kept as the first response bit
      else if (i_sck_tick && active && (!hunting || !i_miso))
      begin
        hunting <= 1'b0;
        o_rsp   <= {o_rsp[sdcard_cfg_pkg::RSP_MAX_BITS-2:0], i_miso};
        bit_cnt <= bit_cnt + 1'b1;
        if (bit_cnt + 1'b1 == rsp_bits)
        begin
          active <= 1'b0;
          o_done <= 1'b1;
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: design/sdcard_spi_host.sv
`timescale 1ns/1ps
`default_nettype none

module sdcard_spi_host (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      i_bus_req,
  input  logic                      i_bus_write,
  input  sdcard_reg_pkg::bus_addr_t i_bus_addr,
  input  sdcard_reg_pkg::bus_data_t i_bus_data,
  input  logic                      i_spi_ack,
  input  logic                      i_miso,
  output logic                      o_bus_ack,
  output sdcard_reg_pkg::bus_data_t o_bus_data,
  output logic                      o_spi_req,
  output logic                      o_spi_done,
  output logic                      o_sck,
  output logic                      o_cs,
  output logic                      o_mosi
);

  logic                     sck_tick;
  logic                     send_start;
  logic                     busy;
  logic                     rsp_start;
  logic                     rsp_done;
  sdcard_cfg_pkg::cmd_t     cmd;
  sdcard_cfg_pkg::rsp_t     rsp;
  sdcard_cfg_pkg::rsp_len_t rsp_len;

  assign rsp_len = cmd[sdcard_cfg_pkg::RSP_LEN_MSB:sdcard_cfg_pkg::RSP_LEN_LSB];

  sdcard_sck_gen sck_gen_i (
    .clk        (clk),
    .rst        (rst),
    .o_sck      (o_sck),
    .o_sck_tick (sck_tick)
  );

  sdcard_bus_regs bus_regs_i (
    .clk          (clk),
    .rst          (rst),
    .i_bus_req    (i_bus_req),
    .i_bus_write  (i_bus_write),
    .i_bus_addr   (i_bus_addr),
    .i_bus_data   (i_bus_data),
    .i_busy       (busy),
    .i_rsp        (rsp),
    .i_rsp_done   (rsp_done),
    .o_bus_ack    (o_bus_ack),
    .o_bus_data   (o_bus_data),
    .o_send_start (send_start),
    .o_cmd        (cmd)
  );

  sdcard_cmd_engine cmd_engine_i (
    .clk          (clk),
    .rst          (rst),
    .i_send_start (send_start),
    .i_cmd        (cmd),
    .i_sck_tick   (sck_tick),
    .i_spi_ack    (i_spi_ack),
    .i_rsp_done   (rsp_done),
    .o_busy       (busy),
    .o_spi_req    (o_spi_req),
    .o_spi_done   (o_spi_done),
    .o_cs         (o_cs),
    .o_mosi       (o_mosi),
    .o_rsp_start  (rsp_start)
  );

  sdcard_rsp_capture rsp_capture_i (
    .clk        (clk),
    .rst        (rst),
    .i_start    (rsp_start),
    .i_sck_tick (sck_tick),
    .i_miso     (i_miso),
    .i_rsp_len  (rsp_len),
    .o_rsp      (rsp),
    .o_done     (rsp_done)
  );

endmodule

`default_nettype wire

// File: verification/sdcard_card_model.sv
`timescale 1ns/1ps
`default_nettype none

module sdcard_card_model #(
  parameter logic [46:0] RSP_SCRAMBLE = '0
) (
  input  logic        i_sck,
  input  logic        i_cs,
  input  logic        i_mosi,
  input  logic [3:0]  i_delay_bits,
  output logic        o_miso,
  output logic [47:0] o_frame,
  output logic [6:0]  o_bit_cnt
);

  int          rsp_pos;
  int          delay;
  logic [46:0] pattern;

  assign delay   = int'(i_delay_bits);
  assign pattern = o_frame[46:0] ^ RSP_SCRAMBLE;

  initial
  begin
    o_miso    = 1'b1;
    o_frame   = '0;
    o_bit_cnt = '0;
    rsp_pos   = 0;
  end

  // Card latches MOSI on the rising SPI clock
  always @(posedge i_sck)
  begin
    if (i_cs)
    begin
      o_bit_cnt <= '0;
    end
    else if (o_bit_cnt < 7'd48)
    begin
      o_frame   <= {o_frame[46:0], i_mosi};
      o_bit_cnt <= o_bit_cnt + 7'd1;
    end
  end

  // Response goes out on the falling SPI clock
  always @(negedge i_sck)
  begin
    if (i_cs)
    begin
      rsp_pos <= 0;
      o_miso  <= 1'b1;
    end
    else if (o_bit_cnt == 7'd48)
    begin
      if (rsp_pos < delay)
      begin
        o_miso <= 1'b1;
      end
      else if (rsp_pos == delay)
      begin
        o_miso <= 1'b0;
      end
      else if (rsp_pos <= delay + 47)
      begin
        o_miso <= pattern[46 - (rsp_pos - delay - 1)];
      end
      else
      begin
        o_miso <= 1'b1;
      end
      rsp_pos <= rsp_pos + 1;
    end
  end

endmodule

`default_nettype wire

// File: verification/tb_sdcard_spi_host.sv
`timescale 1ns/1ps
`default_nettype none

module tb_sdcard_spi_host;

  localparam logic [31:0] LCG_SEED        = 32'd43807;
  localparam int          BUS_TIMEOUT     = 20;
  localparam int          SEND_TIMEOUT    = 3000;
  localparam int          NUM_SENDS       = 12;
  localparam int          SCK_HIGH_CYCLES = 4;
  localparam int          SCK_LOW_CYCLES  = 3;
  localparam logic [47:0] SCRAMBLE_SRC    = 48'h5A5A_C3C3_F0F0;
  localparam logic [46:0] RSP_SCRAMBLE    = SCRAMBLE_SRC[46:0];

  logic                      clk;
  logic                      rst;
  logic                      i_bus_req;
  logic                      i_bus_write;
  sdcard_reg_pkg::bus_addr_t i_bus_addr;
  sdcard_reg_pkg::bus_data_t i_bus_data;
  logic                      i_spi_ack;
  logic                      miso;
  logic                      o_bus_ack;
  sdcard_reg_pkg::bus_data_t o_bus_data;
  logic                      o_spi_req;
  logic                      o_spi_done;
  logic                      o_sck;
  logic                      o_cs;
  logic                      o_mosi;

  logic [3:0]  miso_delay;
  logic [47:0] card_frame;
  logic [6:0]  card_bits;
  logic [31:0] lcg_state;
  int          value_errors = 0;
  int          other_errors = 0;
  logic        sck_last     = 1'b0;
  int          sck_run      = 0;
  bit          sck_rose     = 1'b0;

  // Expected bus acks, in order
  string       exp_name_q[$];
  logic [31:0] exp_data_q[$];
  bit          exp_check_q[$];

  sdcard_spi_host dut_i (
    .clk         (clk),
    .rst         (rst),
    .i_bus_req   (i_bus_req),
    .i_bus_write (i_bus_write),
    .i_bus_addr  (i_bus_addr),
    .i_bus_data  (i_bus_data),
    .i_spi_ack   (i_spi_ack),
    .i_miso      (miso),
    .o_bus_ack   (o_bus_ack),
    .o_bus_data  (o_bus_data),
    .o_spi_req   (o_spi_req),
    .o_spi_done  (o_spi_done),
    .o_sck       (o_sck),
    .o_cs        (o_cs),
    .o_mosi      (o_mosi)
  );

  sdcard_card_model #(
    .RSP_SCRAMBLE (RSP_SCRAMBLE)
  ) card_i (
    .i_sck        (o_sck),
    .i_cs         (o_cs),
    .i_mosi       (o_mosi),
    .i_delay_bits (miso_delay),
    .o_miso       (miso),
    .o_frame      (card_frame),
    .o_bit_cnt    (card_bits)
  );

  initial
  begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  function automatic logic [31:0] next_random();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  function automatic int random_below(input int n);
    return int'((next_random() >> 16) % n);
  endfunction

  // Start bit, then the top of the scrambled frame, right-aligned
  function automatic logic [47:0] expected_response(input logic [63:0] cmd);
    logic [47:0] pattern;
    int          len;
    len     = int'(cmd[62:56]);
    pattern = {1'b0, cmd[46:0] ^ RSP_SCRAMBLE};
    return pattern >> (48 - 8 * len);
  endfunction

  task automatic compare_value(input string name, input logic [63:0] exp,
                               input logic [63:0] act);
    if (act !== exp)
    begin
      value_errors++;
      $display("error at %0t: %s expected %0h got %0h", $time, name, exp, act);
    end
  endtask

  task automatic expect_ack(input string name, input logic [31:0] data, input bit check);
    exp_name_q.push_back(name);
    exp_data_q.push_back(data);
    exp_check_q.push_back(check);
  endtask

  task automatic bus_access(input logic write, input sdcard_reg_pkg::reg_index_t index,
                            input logic [31:0] wdata, input string name,
                            input logic [31:0] exp, input bit check);
    int cycles;
    expect_ack(name, exp, check);
    @(posedge clk);
    i_bus_req   <= 1'b1;
    i_bus_write <= write;
    i_bus_addr  <= {index, 2'b00};
    i_bus_data  <= wdata;
    @(posedge clk);
    i_bus_req <= 1'b0;
    cycles = 0;
    do
    begin
      @(negedge clk);
      cycles++;
    end while (!o_bus_ack && cycles < BUS_TIMEOUT);
    if (!o_bus_ack)
    begin
      other_errors++;
      $display("timeout at %0t: no bus ack for register index %0d", $time, index);
    end
    else if (cycles != 1)
    begin
      compare_value("o_bus_ack latency", 64'd1, 64'(cycles));
    end
  endtask

  task automatic run_send(input logic [63:0] cmd, input int ack_delay, input int rsp_delay);
    int          cycles;
    bit          cs_high_seen;
    logic [47:0] exp_rsp;
    exp_rsp = expected_response(cmd);
    bus_access(1'b1, sdcard_reg_pkg::REG_CMD_LO, cmd[31:0], "o_bus_data", '0, 1'b0);
    bus_access(1'b1, sdcard_reg_pkg::REG_CMD_HI, cmd[63:32], "o_bus_data", '0, 1'b0);
    expect_ack("o_bus_data (send)", '0, 1'b0);
    @(posedge clk);
    i_bus_req   <= 1'b1;
    i_bus_write <= 1'b1;
    i_bus_addr  <= {sdcard_reg_pkg::REG_SEND, 2'b00};
    i_bus_data  <= '0;
    miso_delay  <= 4'(rsp_delay);
    @(posedge clk);
    i_bus_req <= 1'b0;
    @(negedge clk);
    compare_value("o_spi_req", 64'd1, 64'(o_spi_req));
    // Arbiter holds off
    repeat (ack_delay)
    begin
      @(negedge clk);
      compare_value("o_cs", 64'd1, 64'(o_cs));
      compare_value("o_spi_req", 64'd1, 64'(o_spi_req));
      compare_value("card bit count", 64'd0, 64'(card_bits));
    end
    @(posedge clk);
    i_spi_ack <= 1'b1;
    @(posedge clk);
    i_spi_ack <= 1'b0;
    @(negedge clk);
    compare_value("o_spi_req", 64'd0, 64'(o_spi_req));
    cs_high_seen = 1'b0;
    cycles       = 0;
    do
    begin
      @(negedge clk);
      cycles++;
      if (!cs_high_seen && card_bits > 7'd0 && card_bits < 7'd48 && o_cs !== 1'b0)
      begin
        cs_high_seen = 1'b1;
        other_errors++;
        $display("chip select went high while command bits were shifted, at %0t", $time);
      end
    end while (!o_bus_ack && cycles < SEND_TIMEOUT);
    if (!o_bus_ack)
    begin
      other_errors++;
      $display("timeout at %0t: send of command %0h did not complete", $time, cmd);
    end
    else
    begin
      compare_value("o_spi_done", 64'd1, 64'(o_spi_done));
      @(negedge clk);
      compare_value("o_cs", 64'd1, 64'(o_cs));
      compare_value("card frame", 64'(cmd[47:0]), 64'(card_frame));
      bus_access(1'b0, sdcard_reg_pkg::REG_RSP_STATUS, '0, "o_bus_data (RSP_STATUS)",
                 32'd1, 1'b1);
      bus_access(1'b0, sdcard_reg_pkg::REG_RSP_LO, '0, "o_bus_data (RSP_LO)",
                 exp_rsp[31:0], 1'b1);
      bus_access(1'b0, sdcard_reg_pkg::REG_RSP_HI, '0, "o_bus_data (RSP_HI)",
                 {16'd0, exp_rsp[47:32]}, 1'b1);
    end
  endtask

  always @(negedge clk)
  begin : compare_acks
    string       name;
    logic [31:0] data;
    bit          check;
    if (rst === 1'b0)
    begin
      if (o_bus_ack)
      begin
        if (exp_data_q.size() == 0)
        begin
          other_errors++;
          $display("bus ack at %0t with no access outstanding", $time);
        end
        else
        begin
          name  = exp_name_q.pop_front();
          data  = exp_data_q.pop_front();
          check = exp_check_q.pop_front();
          if (check && o_bus_data !== data)
          begin
            value_errors++;
            $display("error at %0t: %s expected %h got %h", $time, name, data, o_bus_data);
          end
        end
      end
      else if (o_bus_data !== '0)
      begin
        value_errors++;
        $display("error at %0t: o_bus_data expected 0 got %h", $time, o_bus_data);
      end
      if (o_spi_done && !o_bus_ack)
      begin
        other_errors++;
        $display("o_spi_done pulsed without a bus ack at %0t", $time);
      end
    end
  end

  // SPI clock high for 4 and low for 3 of every 7 clk cycles
  always @(negedge clk)
  begin : check_sck_shape
    if (rst === 1'b0)
    begin
      if (o_sck !== sck_last)
      begin
        if (sck_last === 1'b1)
        begin
          compare_value("o_sck high cycles", 64'(SCK_HIGH_CYCLES), 64'(sck_run));
        end
        else if (sck_rose)
        begin
          compare_value("o_sck low cycles", 64'(SCK_LOW_CYCLES), 64'(sck_run));
        end
        if (o_sck === 1'b1)
        begin
          sck_rose = 1'b1;
        end
        sck_run = 0;
      end
      sck_run++;
      sck_last = o_sck;
    end
  end

  initial
  begin : stimulus
    logic [31:0]                lo;
    logic [31:0]                hi;
    logic [6:0]                 len;
    sdcard_reg_pkg::reg_index_t idx;
    rst         = 1'b1;
    i_bus_req   = 1'b0;
    i_bus_write = 1'b0;
    i_bus_addr  = '0;
    i_bus_data  = '0;
    i_spi_ack   = 1'b0;
    miso_delay  = 4'd1;
    lcg_state   = LCG_SEED;
    repeat (2) @(posedge clk);
    rst <= 1'b0;
    @(negedge clk);
    compare_value("o_cs", 64'd1, 64'(o_cs));
    compare_value("o_mosi", 64'd1, 64'(o_mosi));
    compare_value("o_spi_req", 64'd0, 64'(o_spi_req));
    compare_value("o_bus_ack", 64'd0, 64'(o_bus_ack));
    compare_value("o_sck", 64'd0, 64'(o_sck));
    for (idx = sdcard_reg_pkg::REG_CMD_LO; idx <= sdcard_reg_pkg::REG_RSP_HI; idx++)
      bus_access(1'b0, idx, '0, $sformatf("o_bus_data (index %0d)", idx), '0, 1'b1);

    // Command halves read back
    repeat (4)
    begin
      lo = next_random();
      hi = next_random();
      bus_access(1'b1, sdcard_reg_pkg::REG_CMD_LO, lo, "o_bus_data", '0, 1'b0);
      bus_access(1'b1, sdcard_reg_pkg::REG_CMD_HI, hi, "o_bus_data", '0, 1'b0);
      bus_access(1'b0, sdcard_reg_pkg::REG_CMD_LO, '0, "o_bus_data (CMD_LO)", lo, 1'b1);
      bus_access(1'b0, sdcard_reg_pkg::REG_CMD_HI, '0, "o_bus_data (CMD_HI)", hi, 1'b1);
      bus_access(lo[5], sdcard_reg_pkg::REG_NOOP, hi, "o_bus_data (NOOP)", '0, 1'b1);
      idx = 30'(7 + random_below(1000));
      bus_access(hi[9], idx, lo, "o_bus_data (unmapped)", '0, 1'b1);
    end

    for (int s = 0; s < NUM_SENDS; s++)
    begin
      len = (s < 6) ? 7'(s + 1) : 7'(1 + random_below(6));
      hi  = next_random();
      lo  = next_random();
      hi[30:24] = len;
      run_send({hi, lo}, random_below(16), 1 + random_below(8));
    end

    repeat (4) @(posedge clk);
    $display("value errors: %0d, other errors: %0d", value_errors, other_errors);
    if (value_errors == 0 && other_errors == 0)
      $display("TB PASSED");
    else
      $display("TB FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// File: filelist.f
design/sdcard_cfg_pkg.sv
design/sdcard_reg_pkg.sv
design/sdcard_sck_gen.sv
design/sdcard_bus_regs.sv
design/sdcard_cmd_engine.sv
design/sdcard_rsp_capture.sv
design/sdcard_spi_host.sv
verification/sdcard_card_model.sv
verification/tb_sdcard_spi_host.sv

// File: Makefile
TOP = tb_sdcard_spi_host

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the simulation into sim.log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing -Wno-fatal --top-module $(TOP) -f filelist.f -Mdir obj_dir
	./obj_dir/V$(TOP) > sim.log 2>&1
	@cat sim.log
	@if grep -q "TB FAILED" sim.log; then echo "Simulation reported failure"; exit 1; fi

clean:
	rm -rf obj_dir sim.log
